/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset
`define FETCH_RESET_PC 64'h8000_0000

// direct-mapped icache geometry
`define ICACHE_LINES 64
`define ICACHE_LINE_BYTES 8

// pc width
`define FETCH_XLEN 64

// wishbone bus widths
// one bus beat carries a whole cache line
`define WB_DATA_W 64
`define WB_ADDR_W 32

`endif

/* fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

	// instruction handed to decode
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] pc;
		logic [31:0]            inst;
	} fetch_t;

	// wishbone master to slave
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`WB_ADDR_W-1:0]    adr;
		logic [`WB_DATA_W/8-1:0]  sel;
	} wb_m2s_t;

	// wishbone slave to master
	typedef struct packed {
		logic                  ack;
		logic [`WB_DATA_W-1:0] dat;
	} wb_s2m_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL
	} icache_state_e;

	// only jal matters to predecode
	typedef enum logic [6:0] {
		OP_JAL   = 7'b1101111,
		OP_OTHER = 7'b0000000
	} opcode_e;

endpackage

/* pc_gen.sv */
`include "fetch_config.svh"

module pc_gen (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ena,
	input  logic                   branch,
	input  logic [`FETCH_XLEN-1:0] branch_pc,
	output logic                   req_valid,
	output logic [`FETCH_XLEN-1:0] req_addr,
	input  logic                   addr_ok,
	input  logic                   data_ok,
	input  logic [31:0]            rdata,
	output logic                   fetch_valid,
	output fetch_pkg::fetch_t      fetch,
	output logic                   jump
);
	import fetch_pkg::*;

	logic [`FETCH_XLEN-1:0] pc;
	logic [`FETCH_XLEN-1:0] jal_offset;
	logic [`FETCH_XLEN-1:0] next_pc;
	logic                   outstanding;
	logic                   kill;
	logic                   accept;
	logic                   consume;
	logic                   deliver;

	assign accept  = req_valid && addr_ok;
	assign consume = fetch_valid && ena;
	// response of a redirected request is dropped
	assign deliver = data_ok && !kill && !branch;

	// one request at a time, none while decode holds an instruction
	assign req_valid = !outstanding && !fetch_valid;
	assign req_addr  = pc;

	// predecode of the held word
	assign jump = fetch_valid && (fetch.inst[6:0] == OP_JAL);
	assign jal_offset = {{(`FETCH_XLEN - 20){fetch.inst[31]}}, fetch.inst[19:12],
		fetch.inst[20], fetch.inst[30:21], 1'b0};
	assign next_pc = jump ? pc + jal_offset : pc + `FETCH_XLEN'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= `FETCH_RESET_PC;
			fetch_valid <= 1'b0;
			outstanding <= 1'b0;
			kill        <= 1'b0;
		end else begin
			// redirect wins over jal and sequential
			if (branch)
				pc <= branch_pc;
			else if (consume)
				pc <= next_pc;

			if (branch)
				fetch_valid <= 1'b0;
			else if (deliver)
				fetch_valid <= 1'b1;
			else if (consume)
				fetch_valid <= 1'b0;

			if (accept)
				outstanding <= 1'b1;
			else if (data_ok)
				outstanding <= 1'b0;

			// request accepted this cycle is also on the old path
			if (data_ok)
				kill <= 1'b0;
			else if (branch && (outstanding || accept))
				kill <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (deliver) begin
			fetch.pc   <= pc;
			fetch.inst <= rdata;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00);

	// icache only answers requests that pc_gen made
	a_resp_expected: assert property (@(posedge clk) disable iff (reset)
		data_ok |-> outstanding);

endmodule

/* icache.sv */
`include "fetch_config.svh"

module icache (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   req_valid,
	input  logic [`FETCH_XLEN-1:0] req_addr,
	output logic                   addr_ok,
	output logic                   data_ok,
	output logic [31:0]            rdata,
	output fetch_pkg::wb_m2s_t     wb_o,
	input  fetch_pkg::wb_s2m_t     wb_i
);
	import fetch_pkg::*;

	localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
	localparam int IDX_W = $clog2(`ICACHE_LINES);
	localparam int TAG_W = `WB_ADDR_W - IDX_W - OFF_W;

	icache_state_e state;

	// held request address, only the physical part
	logic [`WB_ADDR_W-1:0] addr_q;

	logic [TAG_W-1:0]      tag_mem  [`ICACHE_LINES];
	logic [`WB_DATA_W-1:0] data_mem [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] valid_q;

	logic [IDX_W-1:0]      index;
	logic [TAG_W-1:0]      tag;
	logic [`WB_DATA_W-1:0] line;
	logic                  hit;
	logic                  accept;
	logic                  refill_done;
	logic                  bus_req;

	assign index = addr_q[OFF_W +: IDX_W];
	assign tag   = addr_q[OFF_W + IDX_W +: TAG_W];
	assign line  = data_mem[index];
	assign hit   = valid_q[index] && (tag_mem[index] == tag);

	assign addr_ok     = (state == ST_IDLE);
	assign accept      = req_valid && addr_ok;
	assign data_ok     = (state == ST_LOOKUP) && hit;
	assign refill_done = (state == ST_REFILL) && wb_i.ack;

	// pick the 32-bit half holding the requested word
	assign rdata = addr_q[OFF_W-1] ? line[32 +: 32] : line[0 +: 32];

	always_comb begin
		wb_o.cyc = bus_req;
		wb_o.stb = bus_req;
		wb_o.we  = 1'b0;
		wb_o.adr = {addr_q[`WB_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
		wb_o.sel = '1;
	end

	always_ff @(posedge clk) begin
		if (accept)
			addr_q <= req_addr[`WB_ADDR_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= ST_IDLE;
			valid_q <= '0;
			bus_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					if (hit) begin
						state <= ST_IDLE;
					end else begin
						// miss starts the line read
						state   <= ST_REFILL;
						bus_req <= 1'b1;
					end
				end
				ST_REFILL: begin
					if (wb_i.ack) begin
						// back to lookup, which now hits
						state          <= ST_LOOKUP;
						bus_req        <= 1'b0;
						valid_q[index] <= 1'b1;
					end
				end
				default: begin
					state   <= ST_IDLE;
					bus_req <= 1'b0;
				end
			endcase
		end
	end

	// line arrays
	always_ff @(posedge clk) begin
		if (refill_done) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= wb_i.dat;
		end
	end

	a_stb_in_refill: assert property (@(posedge clk) disable iff (reset)
		wb_o.stb |-> wb_o.cyc && (state == ST_REFILL));

	// no physical space above 32 bits
	a_addr_upper_zero: assert property (@(posedge clk) disable iff (reset)
		accept |-> (req_addr[`FETCH_XLEN-1:`WB_ADDR_W] == '0));

	// classic cycle holds until the slave acks
	a_hold_until_ack: assert property (@(posedge clk) disable iff (reset)
		wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

endmodule

/* ifu.sv */
`include "fetch_config.svh"

module ifu (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ena,
	input  logic                   branch,
	input  logic [`FETCH_XLEN-1:0] branch_pc,
	output logic                   fetch_valid,
	output fetch_pkg::fetch_t      fetch,
	output logic                   jump,
	output logic                   if_stall,
	output fetch_pkg::wb_m2s_t     wb_o,
	input  fetch_pkg::wb_s2m_t     wb_i
);

	// request handshake between pc_gen and icache
	logic                   req_valid;
	logic [`FETCH_XLEN-1:0] req_addr;
	logic                   addr_ok;
	logic                   data_ok;
	logic [31:0]            rdata;

	pc_gen pc_gen_i (
		.clk         (clk),
		.reset       (reset),
		.ena         (ena),
		.branch      (branch),
		.branch_pc   (branch_pc),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.rdata       (rdata),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.jump        (jump)
	);

	icache icache_i (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.addr_ok   (addr_ok),
		.data_ok   (data_ok),
		.rdata     (rdata),
		.wb_o      (wb_o),
		.wb_i      (wb_i)
	);

	// decode waits whenever nothing is offered
	assign if_stall = !fetch_valid;

endmodule

/* tb_mem.sv */
`include "fetch_config.svh"

module tb_mem (
	input  logic               clk,
	input  logic               reset,
	input  fetch_pkg::wb_m2s_t m2s,
	output fetch_pkg::wb_s2m_t s2m,
	output int                 ack_count
);
	import fetch_pkg::*;

	localparam int PROG_WORDS = 32;
	localparam logic [31:0] BASE = 32'(`FETCH_RESET_PC);

	logic [31:0] prog [PROG_WORDS];
	logic [31:0] lfsr;
	logic [31:0] adr_off;
	logic [1:0]  draw;
	logic [1:0]  wait_left;
	logic        busy;
	logic        ack_q;
	logic [63:0] dat_q;

	assign adr_off = m2s.adr - BASE;
	assign s2m.ack = ack_q && !reset;
	assign s2m.dat = reset ? '0 : dat_q;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [11:0] imm);
		return {imm, 5'd0, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	// filler scrambled from every address bit
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		logic [31:0] h;
		h = a ^ (a >> 11) ^ (a >> 23);
		return addi_word(h[6:2], h[13:2]);
	endfunction

	initial begin
		for (int i = 0; i < PROG_WORDS; i++)
			prog[i] = fill_word(BASE + 32'(i * 4));
		// forward jal over words 4 to 6
		prog[3] = jal_word(5'd1, 21'd16);
		// back to word 7, a three word loop
		prog[9] = jal_word(5'd0, 21'h1f_fff8);
	end

	always @(posedge clk) begin
		if (reset) begin
			ack_q     <= 1'b0;
			dat_q     <= '0;
			busy      <= 1'b0;
			wait_left <= 2'd0;
			ack_count <= 0;
			lfsr = 32'h0778_aa3d;
		end else begin
			ack_q <= 1'b0;
			if (m2s.cyc && m2s.stb && !ack_q) begin
				if (!busy) begin
					// two wait state bits, one lfsr step each
					draw[0] = lfsr[0];
					lfsr = lfsr_next(lfsr);
					draw[1] = lfsr[0];
					lfsr = lfsr_next(lfsr);
					busy      <= 1'b1;
					wait_left <= draw;
				end else if (wait_left != 2'd0) begin
					wait_left <= wait_left - 2'd1;
				end else begin
					ack_q     <= 1'b1;
					dat_q     <= {prog[{adr_off[6:3], 1'b1}], prog[{adr_off[6:3], 1'b0}]};
					busy      <= 1'b0;
					ack_count <= ack_count + 1;
				end
			end
		end
	end

endmodule

/* tb_fetch.sv */
`include "fetch_config.svh"

module tb_fetch;
	import fetch_pkg::*;

	localparam int NROWS = 16;
	localparam int CYCLE_LIMIT = NROWS * 12 + 200;
	localparam logic [63:0] BASE = `FETCH_RESET_PC;
	// what a row does after its stall cycles
	localparam logic [1:0] ACT_NEXT = 2'd0;
	localparam logic [1:0] ACT_BRANCH = 2'd1;
	localparam logic [1:0] ACT_BRANCH_MISS = 2'd2;

	typedef struct packed {
		logic [2:0]  stall;
		logic [1:0]  act;
		logic [63:0] target;
	} row_t;

	logic        clk;
	logic        reset;
	logic        ena;
	logic        branch;
	logic [63:0] branch_pc;
	logic        fetch_valid;
	logic        jump;
	logic        if_stall;
	fetch_t      fetch;
	wb_m2s_t     wb_o;
	wb_s2m_t     wb_i;
	int          ack_count;
	row_t        rows [NROWS];
	logic [15:0] lines_seen;
	int          checks;
	int          errors;
	int          cycles;

	ifu dut_i (.*);
	tb_mem mem_i (.clk, .reset, .m2s(wb_o), .s2m(wb_i), .ack_count);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// jal goes to pc plus the J immediate, anything else to pc+4
	function automatic logic [63:0] next_pc_of(input logic [63:0] pc, input logic [31:0] inst);
		logic [20:0] imm;
		imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		if (inst[6:0] == OP_JAL)
			return pc + {{43{imm[20]}}, imm};
		return pc + 64'd4;
	endfunction

	task automatic check(string name, logic [63:0] actual, logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic mark_line(input logic [63:0] pc);
		logic [63:0] off;
		off = pc - BASE;
		lines_seen[off[6:3]] = 1'b1;
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: fetch did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [63:0] exp_pc;
		logic [63:0] off;
		logic [31:0] exp_inst;
		// stall cycles, action, branch target
		// word 18 misses in the cache when the second branch comes
		rows = '{
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd2, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd1, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd4, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd3, ACT_NEXT, 64'd0},
			'{3'd2, ACT_BRANCH, BASE + 64'h40},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd0, ACT_BRANCH_MISS, BASE + 64'h60},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd0, ACT_NEXT, 64'd0},
			'{3'd1, ACT_NEXT, 64'd0}
		};
		checks = 0;
		errors = 0;
		lines_seen = '0;
		reset = 1'b1;
		ena = 1'b0;
		branch = 1'b0;
		branch_pc = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		check("fetch_valid", 64'(fetch_valid), 64'd0);
		check("jump", 64'(jump), 64'd0);
		check("wb_o.cyc", 64'(wb_o.cyc), 64'd0);
		check("wb_o.stb", 64'(wb_o.stb), 64'd0);
		exp_pc = BASE;
		for (int r = 0; r < NROWS; r++) begin
			while (!fetch_valid) begin
				check("if_stall", 64'(if_stall), 64'd1);
				// a refill is a plain read of the whole line
				if (wb_o.stb) begin
					check("wb_o.we", 64'(wb_o.we), 64'd0);
					check("wb_o.sel", 64'(wb_o.sel), 64'hff);
				end
				next_cycle();
			end
			off = exp_pc - BASE;
			exp_inst = mem_i.prog[off[6:2]];
			check("if_stall", 64'(if_stall), 64'd0);
			check("fetch.pc", fetch.pc, exp_pc);
			check("fetch.inst", 64'(fetch.inst), 64'(exp_inst));
			check("jump", 64'(jump), 64'(exp_inst[6:0] == OP_JAL));
			mark_line(exp_pc);
			// decode not ready so the offer holds
			for (int k = 0; k < int'(rows[r].stall); k++) begin
				next_cycle();
				check("fetch_valid", 64'(fetch_valid), 64'd1);
				check("fetch.pc", fetch.pc, exp_pc);
				check("fetch.inst", 64'(fetch.inst), 64'(exp_inst));
				check("jump", 64'(jump), 64'(exp_inst[6:0] == OP_JAL));
			end
			if (r == NROWS - 1)
				break;
			if (rows[r].act == ACT_BRANCH) begin
				branch = 1'b1;
				branch_pc = rows[r].target;
				next_cycle();
				branch = 1'b0;
				exp_pc = rows[r].target;
			end else begin
				ena = 1'b1;
				next_cycle();
				ena = 1'b0;
				exp_pc = next_pc_of(exp_pc, exp_inst);
				if (rows[r].act == ACT_BRANCH_MISS) begin
					// accept, lookup miss, refill now on the bus
					repeat (2) next_cycle();
					check("wb_o.stb", 64'(wb_o.stb), 64'd1);
					check("wb_o.adr", 64'(wb_o.adr), 64'({exp_pc[31:3], 3'b000}));
					mark_line(exp_pc);
					branch = 1'b1;
					branch_pc = rows[r].target;
					next_cycle();
					branch = 1'b0;
					exp_pc = rows[r].target;
				end
			end
		end
		repeat (4) next_cycle();
		// one read per distinct line, so the second loop pass hit
		check("ack_count", 64'(ack_count), 64'($countones(lines_seen)));
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
fetch_pkg.sv
pc_gen.sv
icache.sv
ifu.sv
tb_mem.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_fetch -f tb.f -o tb_fetch_sim
out=$(./obj_dir/tb_fetch_sim)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
